// File: hdl/backend_macros.svh
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// operand and result width
`define DATA_WIDTH 32

// reorder buffer entries, power of two
`define ROB_DEPTH 8

// multiply acceptance to its bus slot, in cycles
`define MUL_LATENCY 3

`endif

// File: hdl/backend_pkg.sv
`include "backend_macros.svh"

package backend_pkg;

	// mov passes operand b, mul keeps the low half of the product
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MOV = 2'd2,
		OP_MUL = 2'd3
	} op_t;

	// reorder buffer index
	typedef logic [$clog2(`ROB_DEPTH)-1:0] tag_t;

	typedef logic [`DATA_WIDTH-1:0] data_t;

	// one beat on the result bus
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		data_t data;
	} cdb_t;

endpackage

// File: hdl/unit_issue_if.sv
interface unit_issue_if;

	// strobe, high only in the accepting cycle
	logic               valid;
	backend_pkg::op_t   op;
	backend_pkg::tag_t  tag;
	backend_pkg::data_t a;
	backend_pkg::data_t b;

	modport src (
		output valid, op, tag, a, b
	);

	modport unit (
		input valid, op, tag, a, b
	);

	// scheduler only follows the booking
	modport mon (
		input valid, tag
	);

endinterface

// File: hdl/bus_req_if.sv
interface bus_req_if;

	logic               req;
	backend_pkg::tag_t  tag;
	backend_pkg::data_t data;
	// only with req, closes the request
	logic               grant;

	modport unit (
		output req, tag, data,
		input  grant
	);

	modport sched (
		input  req, tag, data,
		output grant
	);

endinterface

// File: hdl/issue_ctrl.sv
module issue_ctrl (
	input  logic               issue_valid,
	input  backend_pkg::op_t   issue_op,
	input  backend_pkg::data_t issue_a,
	input  backend_pkg::data_t issue_b,
	input  backend_pkg::tag_t  alloc_tag,
	input  logic               rob_full,
	input  logic               alu_ready,
	output logic               issue_ready,
	output logic               alloc,
	unit_issue_if.src          alu_issue,
	unit_issue_if.src          mul_issue
);
	import backend_pkg::*;

	logic is_mul;
	logic accept;

	assign is_mul = issue_op == OP_MUL;

	// multiplier never stalls, so only the rob gates a mul
	assign issue_ready = !rob_full && (is_mul || alu_ready);
	assign accept      = issue_valid && issue_ready;
	assign alloc       = accept;

	// alu side
	assign alu_issue.valid = accept && !is_mul;
	assign alu_issue.op    = issue_op;
	assign alu_issue.tag   = alloc_tag;
	assign alu_issue.a     = issue_a;
	assign alu_issue.b     = issue_b;

	// mul side
	assign mul_issue.valid = accept && is_mul;
	assign mul_issue.op    = issue_op;
	assign mul_issue.tag   = alloc_tag;
	assign mul_issue.a     = issue_a;
	assign mul_issue.b     = issue_b;

endmodule

// File: hdl/alu_unit.sv
module alu_unit (
	input  logic       clk,
	input  logic       rst_n,
	unit_issue_if.unit issue,
	output logic       alu_ready,
	bus_req_if.unit    bus
);
	import backend_pkg::*;

	data_t result;
	logic  hold_valid;
	tag_t  hold_tag;
	data_t hold_data;

	always_comb begin
		case (issue.op)
			OP_ADD:  result = issue.a + issue.b;
			OP_SUB:  result = issue.a - issue.b;
			default: result = issue.b;
		endcase
	end

	// register frees in the cycle it is granted
	assign alu_ready = !hold_valid || bus.grant;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
		end else if (issue.valid) begin
			hold_valid <= 1'b1;
		end else if (bus.grant) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (issue.valid) begin
			hold_tag  <= issue.tag;
			hold_data <= result;
		end
	end

	// stays on the lines until granted
	assign bus.req  = hold_valid;
	assign bus.tag  = hold_tag;
	assign bus.data = hold_data;

endmodule

// File: hdl/mul_unit.sv
`include "backend_macros.svh"

module mul_unit (
	input  logic               clk,
	unit_issue_if.unit         issue,
	output backend_pkg::data_t mul_result
);
	import backend_pkg::*;

	data_t a_q;
	data_t b_q;
	data_t product;

	// first stage, operands
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			a_q <= issue.a;
			b_q <= issue.b;
		end
	end

	// low half only
	assign product = a_q * b_q;

	if (`MUL_LATENCY > 1) begin : g_pipe
		data_t pipe [`MUL_LATENCY-1];

		always_ff @(posedge clk) begin
			pipe[0] <= product;
			for (int i = 1; i < `MUL_LATENCY-1; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end

		assign mul_result = pipe[`MUL_LATENCY-2];
	end else begin : g_comb
		assign mul_result = product;
	end

endmodule

// File: hdl/cdb_sched.sv
`include "backend_macros.svh"

module cdb_sched (
	input  logic               clk,
	input  logic               rst_n,
	unit_issue_if.mon          mul_issue,
	input  backend_pkg::data_t mul_result,
	bus_req_if.sched           alu_bus,
	output backend_pkg::cdb_t  cdb
);
	import backend_pkg::*;

	localparam int SLOTS = `MUL_LATENCY;

	logic [SLOTS-1:0] slot_valid;
	tag_t             slot_tag [SLOTS];
	logic             mul_owns;

	////////////////////////////////////////////////////////////////////////////
	// reservation chain, slot 0 owns the bus this cycle
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			slot_valid[SLOTS-1] <= mul_issue.valid;
			for (int i = 0; i < SLOTS-1; i++) begin
				slot_valid[i] <= slot_valid[i+1];
			end
		end
	end

	always_ff @(posedge clk) begin
		slot_tag[SLOTS-1] <= mul_issue.tag;
		for (int i = 0; i < SLOTS-1; i++) begin
			slot_tag[i] <= slot_tag[i+1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus mux
	////////////////////////////////////////////////////////////////////////////

	assign mul_owns = slot_valid[0];

	// alu fills any slot left free
	assign alu_bus.grant = alu_bus.req && !mul_owns;

	assign cdb.valid = mul_owns || alu_bus.req;
	assign cdb.tag   = mul_owns ? slot_tag[0] : alu_bus.tag;
	assign cdb.data  = mul_owns ? mul_result : alu_bus.data;

endmodule

// File: hdl/rob.sv
`include "backend_macros.svh"

module rob (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               alloc,
	input  backend_pkg::cdb_t  cdb,
	input  logic               commit_ready,
	output backend_pkg::tag_t  alloc_tag,
	output logic               rob_full,
	output logic               commit_valid,
	output backend_pkg::tag_t  commit_tag,
	output backend_pkg::data_t commit_data
);
	import backend_pkg::*;

	localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

	tag_t               head;
	tag_t               tail;
	logic [CNT_W-1:0]   count;
	logic [`ROB_DEPTH-1:0] done;
	data_t              data_q [`ROB_DEPTH];
	logic               commit;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	assign alloc_tag = tail;
	assign rob_full  = count == CNT_W'(`ROB_DEPTH);
	assign commit    = commit_valid && commit_ready;

	// ring wraps on its own, depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1;
			end
			if (commit) begin
				head <= head + 1'b1;
			end
			case ({alloc, commit})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// entries
	////////////////////////////////////////////////////////////////////////////

	// bus tag is always an outstanding entry, never the tail
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= '0;
		end else begin
			if (alloc) begin
				done[tail] <= 1'b0;
			end
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			data_q[cdb.tag] <= cdb.data;
		end
	end

	// oldest entry only
	assign commit_valid = count != '0 && done[head];
	assign commit_tag   = head;
	assign commit_data  = data_q[head];

endmodule

// File: hdl/int_backend.sv
module int_backend (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  backend_pkg::op_t   issue_op,
	input  backend_pkg::data_t issue_a,
	input  backend_pkg::data_t issue_b,
	output logic               issue_ready,
	output logic               cdb_valid,
	output backend_pkg::tag_t  cdb_tag,
	output backend_pkg::data_t cdb_data,
	output logic               commit_valid,
	output backend_pkg::tag_t  commit_tag,
	output backend_pkg::data_t commit_data,
	input  logic               commit_ready
);
	import backend_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// issue
	////////////////////////////////////////////////////////////////////////////

	unit_issue_if alu_issue();
	unit_issue_if mul_issue();
	tag_t alloc_tag;
	logic rob_full;
	logic alloc;
	logic alu_ready;

	issue_ctrl issue_ctrl (
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.alloc_tag,
		.rob_full,
		.alu_ready,
		.issue_ready,
		.alloc,
		.alu_issue(alu_issue.src),
		.mul_issue(mul_issue.src)
	);

	////////////////////////////////////////////////////////////////////////////
	// units and result bus
	////////////////////////////////////////////////////////////////////////////

	bus_req_if alu_bus();
	data_t mul_result;
	cdb_t  cdb;

	alu_unit alu_unit (
		.clk,
		.rst_n,
		.issue(alu_issue.unit),
		.alu_ready,
		.bus(alu_bus.unit)
	);

	mul_unit mul_unit (
		.clk,
		.issue(mul_issue.unit),
		.mul_result
	);

	cdb_sched cdb_sched (
		.clk,
		.rst_n,
		.mul_issue(mul_issue.mon),
		.mul_result,
		.alu_bus(alu_bus.sched),
		.cdb
	);

	assign cdb_valid = cdb.valid;
	assign cdb_tag   = cdb.tag;
	assign cdb_data  = cdb.data;

	////////////////////////////////////////////////////////////////////////////
	// commit
	////////////////////////////////////////////////////////////////////////////

	rob rob (
		.clk,
		.rst_n,
		.alloc,
		.cdb,
		.commit_ready,
		.alloc_tag,
		.rob_full,
		.commit_valid,
		.commit_tag,
		.commit_data
	);

endmodule

// File: tb/tb_int_backend.sv
`include "backend_macros.svh"

module tb_int_backend;
	import backend_pkg::*;

	localparam int N_INSTR        = 300;
	localparam int TIMEOUT_CYCLES = 20 * N_INSTR;

	typedef struct packed {
		tag_t  tag;
		data_t value;
	} expect_t;

	logic  clk = 1'b0;
	logic  rst_n;
	logic  issue_valid;
	op_t   issue_op;
	data_t issue_a;
	data_t issue_b;
	logic  issue_ready;
	logic  cdb_valid;
	tag_t  cdb_tag;
	data_t cdb_data;
	logic  commit_valid;
	tag_t  commit_tag;
	data_t commit_data;
	logic  commit_ready;

	integer seed = 32'hb8e4_56c2;
	int     errors = 0;
	int     cycles = 0;
	int     accepted = 0;
	int     committed = 0;
	int     full_cycles = 0;
	int     held_cycles = 0;
	int     burst_left = 0;

	// scoreboard state indexed by tag
	expect_t               expected [$];
	logic [`ROB_DEPTH-1:0] pending;
	logic [`ROB_DEPTH-1:0] seen;
	data_t                 value_of [`ROB_DEPTH];
	tag_t                  next_tag;

	// multiplies on their way to the bus with bit 0 due now
	logic [`MUL_LATENCY-1:0] mul_due;
	tag_t                    due_tag [`MUL_LATENCY];

	int_backend DUT (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_op,
		.issue_a,
		.issue_b,
		.issue_ready,
		.cdb_valid,
		.cdb_tag,
		.cdb_data,
		.commit_valid,
		.commit_tag,
		.commit_data,
		.commit_ready
	);

	always #50 clk = ~clk;

	function automatic int pick_below(int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	function automatic data_t op_result(op_t op, data_t a, data_t b);
		logic [2*`DATA_WIDTH-1:0] wide;
		wide = {{`DATA_WIDTH{1'b0}}, a} * {{`DATA_WIDTH{1'b0}}, b};
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_MOV:  return b;
			default: return wide[`DATA_WIDTH-1:0];
		endcase
	endfunction

	task drive_issue;
		logic [1:0] op_bits;
		if (accepted < N_INSTR) begin
			op_bits     = 2'(pick_below(4));
			issue_valid = pick_below(4) != 0;
			issue_op    = op_t'(op_bits);
			issue_a     = $random(seed);
			issue_b     = $random(seed);
		end else begin
			issue_valid = 1'b0;
		end
	endtask

	// commit_ready comes in bursts and the low ones last long enough to fill the rob
	task drive_commit;
		if (burst_left == 0) begin
			commit_ready = pick_below(3) != 0;
			burst_left   = commit_ready ? 1 + pick_below(16) : 4 + pick_below(12);
		end else begin
			burst_left--;
		end
	endtask

	task finish_run;
		$display("run done: %0d of %0d committed, %0d full cycles, %0d held cycles, %0d errors",
			committed, N_INSTR, full_cycles, held_cycles, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : track
		expect_t head_entry;
		logic    mul_accept;
		mul_accept = issue_valid && issue_ready && issue_op == OP_MUL;
		if (!rst_n) begin
			expected.delete();
			pending  = '0;
			seen     = '0;
			next_tag = '0;
			mul_due <= '0;
		end else begin
			if (expected.size() == `ROB_DEPTH) begin
				full_cycles++;
				assert (!issue_ready) else begin
					errors++;
					$display("Error: issue_ready = %h with rob full, expected 0", issue_ready);
				end
			end
			if (commit_valid && !commit_ready) begin
				held_cycles++;
			end
			if (commit_valid && commit_ready) begin
				if (expected.size() == 0) begin
					errors++;
					$display("commit of tag %0d with nothing outstanding", commit_tag);
				end else begin
					head_entry = expected.pop_front();
					assert (commit_tag == head_entry.tag) else begin
						errors++;
						$display("Error: commit_tag = %h, expected %h", commit_tag, head_entry.tag);
					end
					assert (commit_data == head_entry.value) else begin
						errors++;
						$display("Error: commit_data = %h, expected %h",
							commit_data, head_entry.value);
					end
					assert (seen[commit_tag]) else begin
						errors++;
						$display("tag %0d committed before it was on the bus", commit_tag);
					end
					pending[commit_tag] = 1'b0;
					committed++;
				end
			end
			if (cdb_valid) begin
				assert (pending[cdb_tag] && !seen[cdb_tag]) else begin
					errors++;
					$display("tag %0d on the bus while not waiting for a result", cdb_tag);
				end
				assert (!pending[cdb_tag] || cdb_data == value_of[cdb_tag]) else begin
					errors++;
					$display("Error: cdb_data = %h, expected %h", cdb_data, value_of[cdb_tag]);
				end
				seen[cdb_tag] = 1'b1;
			end
			if (issue_valid && issue_ready) begin
				assert (!pending[next_tag]) else begin
					errors++;
					$display("tag %0d accepted again while still outstanding", next_tag);
				end
				value_of[next_tag] = op_result(issue_op, issue_a, issue_b);
				expected.push_back('{tag: next_tag, value: value_of[next_tag]});
				pending[next_tag] = 1'b1;
				seen[next_tag]    = 1'b0;
				accepted++;
			end
			mul_due <= {mul_accept, mul_due[`MUL_LATENCY-1:1]};
			for (int i = 0; i < `MUL_LATENCY-1; i++) begin
				due_tag[i] <= due_tag[i+1];
			end
			due_tag[`MUL_LATENCY-1] <= next_tag;
			if (issue_valid && issue_ready) begin
				next_tag = next_tag + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol and timing
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk) $rose(rst_n) |-> !cdb_valid && !commit_valid && issue_ready)
		else begin
			errors++;
			$display("Error: after reset cdb_valid = %h commit_valid = %h issue_ready = %h",
				$sampled(cdb_valid), $sampled(commit_valid), $sampled(issue_ready));
		end

	// multiply owns its slot even with an alu result waiting
	assert property (@(posedge clk) disable iff (!rst_n)
		mul_due[0] |-> cdb_valid && cdb_tag == due_tag[0])
		else begin
			errors++;
			$display("Error: cdb_tag = %h with cdb_valid = %h, expected multiply tag %h",
				$sampled(cdb_tag), $sampled(cdb_valid), $sampled(due_tag[0]));
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		commit_valid && !commit_ready |=>
			commit_valid && $stable(commit_tag) && $stable(commit_data))
		else begin
			errors++;
			$display("held commit changed, commit_valid %h commit_tag %h commit_data %h",
				$sampled(commit_valid), $sampled(commit_tag), $sampled(commit_data));
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			errors++;
			$display("timeout after %0d cycles with %0d of %0d instructions committed",
				cycles, committed, N_INSTR);
			finish_run();
		end
	end

	initial begin
		rst_n        = 1'b0;
		issue_valid  = 1'b0;
		issue_op     = OP_ADD;
		issue_a      = '0;
		issue_b      = '0;
		commit_ready = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		while (committed < N_INSTR) begin
			@(negedge clk);
			drive_issue();
			drive_commit();
		end
		issue_valid  = 1'b0;
		commit_ready = 1'b1;
		repeat (4) @(negedge clk);
		// drained core is idle and takes new work
		if (commit_valid || cdb_valid || !issue_ready) begin
			errors++;
			$display("Error: commit_valid = %h cdb_valid = %h issue_ready = %h, expected 0 0 1",
				commit_valid, cdb_valid, issue_ready);
		end
		if (full_cycles == 0 || held_cycles == 0) begin
			errors++;
			$display("stimulus never filled the rob or never held a commit");
		end
		finish_run();
	end

endmodule

// File: int_backend.f
+incdir+hdl
hdl/backend_pkg.sv
hdl/unit_issue_if.sv
hdl/bus_req_if.sv
hdl/issue_ctrl.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_sched.sv
hdl/rob.sv
hdl/int_backend.sv
tb/tb_int_backend.sv

// File: run_sim.sh
#!/bin/bash
# builds the int_backend testbench with Verilator and runs it
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_int_backend -f int_backend.f \
	&& ./obj_dir/Vtb_int_backend 2>&1 | tee sim.log \
	&& grep -qx "No errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
